// File: logic/decode_assembler.sv
module decode_assembler (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           valid_i,
  input  rv64_decode_pkg::match_t        match_i,
  input  rv64_decode_pkg::xlen_t         imm_i,
  input  rv64_decode_pkg::reg_idx_t      rd_i,
  input  rv64_decode_pkg::reg_idx_t      rs1_i,
  input  rv64_decode_pkg::reg_idx_t      rs2_i,
  output logic                           valid_o,
  output rv64_decode_pkg::decoded_instr_t cmd_o
);

  import rv64_decode_pkg::*;

  logic           blocking;
  reg_req_t       reg_req;
  decoded_instr_t cmd_d;

  assign blocking = |(match_i.func & BLOCKING_FUNCS);

  // Blocking claims every register; x0 is always flagged
  always_comb begin
    reg_req        = blocking ? '1 : reg_req_t'(1);
    reg_req[rd_i]  = 1'b1;
    reg_req[rs1_i] = 1'b1;
    reg_req[rs2_i] = 1'b1;
  end

  always_comb begin
    cmd_d.func     = match_i.func;
    cmd_d.rd       = rd_i;
    cmd_d.rs1      = rs1_i;
    cmd_d.rs2      = rs2_i;
    cmd_d.imm      = imm_i;
    cmd_d.pc       = match_i.pc;
    cmd_d.blocking = blocking;
    cmd_d.reg_req  = reg_req;
  end

  ////////////////////////////////////////
  // Output register
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_o <= 1'b0;
      cmd_o   <= '0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) cmd_o <= cmd_d;  // Hold between strobes
    end
  end

  // Stage 1 carries no strobe in the first cycle out of reset
  a_quiet_after_reset : assert property (
    @(posedge clk_i) $fell(rst_i) |=> !valid_o
  ) else $error("decode_assembler: valid_o right after reset");

endmodule

// File: logic/imm_gen.sv
module imm_gen (
  input  rv64_decode_pkg::match_t match_i,
  output rv64_decode_pkg::xlen_t  imm_o
);

  import rv64_decode_pkg::*;

  logic [ILEN-1:0] c;
  xlen_t           aimm;
  xlen_t           bimm;
  xlen_t           iimm;
  xlen_t           jimm;
  xlen_t           simm;
  xlen_t           uimm;
  logic [5:0]      grp;  // a, b, i, j, s, u from bit 5 down

  assign c = match_i.code;

  ////////////////////////////////////////
  // Immediate formats
  ////////////////////////////////////////

  assign aimm = {{(XLEN-6){1'b0}}, c[25:20]};  // 6 bit shamt
  assign bimm = {{(XLEN-12){c[31]}}, c[7], c[30:25], c[11:8], 1'b0};
  assign iimm = {{(XLEN-12){c[31]}}, c[31:20]};
  assign jimm = {{(XLEN-20){c[31]}}, c[19:12], c[20], c[30:21], 1'b0};
  assign simm = {{(XLEN-12){c[31]}}, c[31:25], c[11:7]};

  // Upper bits stay zero above 31
  assign uimm = {{(XLEN-32){1'b0}}, c[31:12], 12'b0};

  ////////////////////////////////////////
  // Format select
  ////////////////////////////////////////

  always_comb begin
    grp[5] = |(match_i.func & AIMM_FUNCS);
    grp[4] = |(match_i.func & BIMM_FUNCS);
    grp[3] = |(match_i.func & IIMM_FUNCS);
    grp[2] = |(match_i.func & JIMM_FUNCS);
    grp[1] = |(match_i.func & SIMM_FUNCS);
    grp[0] = |(match_i.func & UIMM_FUNCS);

    if (grp[5]) imm_o = aimm;
    else if (grp[4]) imm_o = bimm;
    else if (grp[3]) imm_o = iimm;
    else if (grp[2]) imm_o = jimm;
    else if (grp[1]) imm_o = simm;
    else if (grp[0]) imm_o = uimm;
    else imm_o = '0;  // Unknown code

    // Group masks and match table must agree on one format per function
    if (!$isunknown(match_i.func)) begin
      a_one_format : assert ($onehot0(grp))
        else $error("imm_gen: several formats active %b", grp);
    end
  end

endmodule

// File: logic/instr_matcher.sv
module instr_matcher (
  input  logic                                    clk_i,
  input  logic                                    rst_i,
  input  logic                                    valid_i,
  input  rv64_decode_pkg::xlen_t                  pc_i,
  input  logic [rv64_decode_pkg::ILEN-1:0]        code_i,
  output logic                                    valid_o,
  output rv64_decode_pkg::match_t                 match_o
);

  import rv64_decode_pkg::*;

  func_vec_t func_hit;
  func_vec_t func_chk;

  ////////////////////////////////////////
  // Mask and compare
  ////////////////////////////////////////

  for (genvar i = 0; i < NUM_FUNCS; i++) begin : g_match
    assign func_hit[i] = ((code_i & FUNC_MASK[i]) == FUNC_MATCH[i]);
  end

  ////////////////////////////////////////
  // Stage 1 register
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin  // Payload only moves on a strobe
      match_o.code <= code_i;
      match_o.pc   <= pc_i;
      match_o.func <= func_hit;
    end
  end

  // FENCE.TSO and PAUSE also fall inside the FENCE pattern
  always_comb begin
    func_chk = match_o.func;
    if (match_o.func[FENCE_TSO] || match_o.func[PAUSE]) begin
      func_chk[FENCE] = 1'b0;
    end
  end

  // Table entries must not overlap apart from the fence family
  a_one_func : assert property (
    @(posedge clk_i) disable iff (rst_i)
    valid_o |-> $onehot0(func_chk)
  ) else $error("instr_matcher: overlapping matches %h", match_o.func);

endmodule

// File: logic/operand_select.sv
module operand_select (
  input  rv64_decode_pkg::match_t   match_i,
  output rv64_decode_pkg::reg_idx_t rd_o,
  output rv64_decode_pkg::reg_idx_t rs1_o,
  output rv64_decode_pkg::reg_idx_t rs2_o
);

  import rv64_decode_pkg::*;

  reg_idx_t rd_fld;
  reg_idx_t rs1_fld;
  reg_idx_t rs2_fld;
  logic     use_rd;
  logic     use_rs1;
  logic     use_rs2;

  // Raw fields
  assign rd_fld  = match_i.code[11:7];
  assign rs1_fld = match_i.code[19:15];
  assign rs2_fld = match_i.code[24:20];

  assign use_rd  = |(match_i.func & XRD_FUNCS);
  assign use_rs1 = |(match_i.func & XRS1_FUNCS);
  assign use_rs2 = |(match_i.func & XRS2_FUNCS);

  // Unused operands read as x0
  assign rd_o  = use_rd ? rd_fld : '0;
  assign rs1_o = use_rs1 ? rs1_fld : '0;
  assign rs2_o = use_rs2 ? rs2_fld : '0;

endmodule

// File: logic/rv64_decode_pkg.sv
package rv64_decode_pkg;

  localparam int XLEN      = 64;
  localparam int ILEN      = 32;
  localparam int NUM_FUNCS = 67;

  ////////////////////////////////////////
  // Function enumeration
  ////////////////////////////////////////

  // Order is the bit position in func_vec_t
  typedef enum int {
    AUIPC, LUI, JAL, JALR,
    BEQ, BNE, BLT, BGE, BLTU, BGEU,
    LB, LH, LW, LBU, LHU,
    SB, SH, SW,
    ADDI, SLTI, SLTIU, XORI, ORI, ANDI,
    SLLI, SRLI, SRAI,
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
    FENCE, FENCE_TSO, PAUSE, ECALL, EBREAK,
    LWU, LD, SD,
    ADDIW, SLLIW, SRLIW, SRAIW,
    ADDW, SUBW, SLLW, SRLW, SRAW,
    MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU,
    MULW, DIVW, DIVUW, REMW, REMUW
  } func_e;

  typedef logic [NUM_FUNCS-1:0] func_vec_t;
  typedef logic [4:0]           reg_idx_t;
  typedef logic [31:0]          reg_req_t;
  typedef logic [XLEN-1:0]      xlen_t;

  ////////////////////////////////////////
  // Match table
  ////////////////////////////////////////

  localparam logic [ILEN-1:0] MSK_OP  = 32'h0000007F;  // opcode
  localparam logic [ILEN-1:0] MSK_F3  = 32'h0000707F;  // + funct3
  localparam logic [ILEN-1:0] MSK_F6  = 32'hFC00707F;  // + funct6 for 64 bit shifts
  localparam logic [ILEN-1:0] MSK_F7  = 32'hFE00707F;  // + funct7
  localparam logic [ILEN-1:0] MSK_ALL = 32'hFFFFFFFF;

  localparam logic [ILEN-1:0] FUNC_MASK [NUM_FUNCS] = '{
    MSK_OP, MSK_OP, MSK_OP, MSK_F3,
    MSK_F3, MSK_F3, MSK_F3, MSK_F3, MSK_F3, MSK_F3,
    MSK_F3, MSK_F3, MSK_F3, MSK_F3, MSK_F3,
    MSK_F3, MSK_F3, MSK_F3,
    MSK_F3, MSK_F3, MSK_F3, MSK_F3, MSK_F3, MSK_F3,
    MSK_F6, MSK_F6, MSK_F6,
    MSK_F7, MSK_F7, MSK_F7, MSK_F7, MSK_F7, MSK_F7, MSK_F7, MSK_F7, MSK_F7, MSK_F7,
    MSK_F3, MSK_ALL, MSK_ALL, MSK_ALL, MSK_ALL,
    MSK_F3, MSK_F3, MSK_F3,
    MSK_F3, MSK_F7, MSK_F7, MSK_F7,
    MSK_F7, MSK_F7, MSK_F7, MSK_F7, MSK_F7,
    MSK_F7, MSK_F7, MSK_F7, MSK_F7, MSK_F7, MSK_F7, MSK_F7, MSK_F7,
    MSK_F7, MSK_F7, MSK_F7, MSK_F7, MSK_F7
  };

  localparam logic [ILEN-1:0] FUNC_MATCH [NUM_FUNCS] = '{
    32'h00000017, 32'h00000037, 32'h0000006F, 32'h00000067,
    32'h00000063, 32'h00001063, 32'h00004063, 32'h00005063, 32'h00006063, 32'h00007063,
    32'h00000003, 32'h00001003, 32'h00002003, 32'h00004003, 32'h00005003,
    32'h00000023, 32'h00001023, 32'h00002023,
    32'h00000013, 32'h00002013, 32'h00003013, 32'h00004013, 32'h00006013, 32'h00007013,
    32'h00001013, 32'h00005013, 32'h40005013,
    32'h00000033, 32'h40000033, 32'h00001033, 32'h00002033, 32'h00003033,
    32'h00004033, 32'h00005033, 32'h40005033, 32'h00006033, 32'h00007033,
    32'h0000000F, 32'h8330000F, 32'h0100000F, 32'h00000073, 32'h00100073,
    32'h00006003, 32'h00003003, 32'h00003023,
    32'h0000001B, 32'h0000101B, 32'h0000501B, 32'h4000501B,
    32'h0000003B, 32'h4000003B, 32'h0000103B, 32'h0000503B, 32'h4000503B,
    32'h02000033, 32'h02001033, 32'h02002033, 32'h02003033,
    32'h02004033, 32'h02005033, 32'h02006033, 32'h02007033,
    32'h0200003B, 32'h0200403B, 32'h0200503B, 32'h0200603B, 32'h0200703B
  };

  ////////////////////////////////////////
  // Function groups
  ////////////////////////////////////////

  // Bits lo..hi of the enumeration order
  function automatic func_vec_t func_range(func_e lo, func_e hi);
    func_vec_t v;
    v = '0;
    for (int i = int'(lo); i <= int'(hi); i++) v[i] = 1'b1;
    return v;
  endfunction

  function automatic func_vec_t func_bit(func_e f);
    return func_range(f, f);
  endfunction

  // FENCE is counted as an rd writer and rs1 reader
  localparam func_vec_t XRD_FUNCS = func_range(AUIPC, JALR) | func_range(LB, LHU)
      | func_range(ADDI, AND) | func_bit(FENCE) | func_range(LWU, LD)
      | func_range(ADDIW, REMUW);
  localparam func_vec_t XRS1_FUNCS = func_range(JALR, AND) | func_bit(FENCE)
      | func_range(LWU, REMUW);
  localparam func_vec_t XRS2_FUNCS = func_range(BEQ, BGEU) | func_range(SB, SW)
      | func_range(ADD, AND) | func_bit(SD) | func_range(ADDW, REMUW);

  localparam func_vec_t AIMM_FUNCS = func_range(SLLI, SRAI) | func_range(SLLIW, SRAIW);
  localparam func_vec_t BIMM_FUNCS = func_range(BEQ, BGEU);
  localparam func_vec_t IIMM_FUNCS = func_bit(JALR) | func_range(LB, LHU)
      | func_range(ADDI, ANDI) | func_range(FENCE, EBREAK) | func_range(LWU, LD)
      | func_bit(ADDIW);
  localparam func_vec_t JIMM_FUNCS = func_bit(JAL);
  localparam func_vec_t SIMM_FUNCS = func_range(SB, SW) | func_bit(SD);
  localparam func_vec_t UIMM_FUNCS = func_range(AUIPC, LUI);

  localparam func_vec_t BLOCKING_FUNCS = func_range(JAL, BGEU) | func_range(FENCE, FENCE_TSO);

  typedef struct packed {
    logic [ILEN-1:0] code;
    xlen_t           pc;
    func_vec_t       func;
  } match_t;

  typedef struct packed {
    func_vec_t func;
    reg_idx_t  rd;
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    xlen_t     imm;
    xlen_t     pc;
    logic      blocking;
    reg_req_t  reg_req;
  } decoded_instr_t;

endpackage

// File: logic/rv64_decoder_top.sv
module rv64_decoder_top (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic                            valid_i,
  input  rv64_decode_pkg::xlen_t          pc_i,
  input  logic [rv64_decode_pkg::ILEN-1:0] code_i,
  output logic                            valid_o,
  output rv64_decode_pkg::decoded_instr_t cmd_o
);

  import rv64_decode_pkg::*;

  logic     s1_valid;
  match_t   s1_match;
  xlen_t    s1_imm;
  reg_idx_t s1_rd;
  reg_idx_t s1_rs1;
  reg_idx_t s1_rs2;

  instr_matcher u_instr_matcher (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .valid_i(valid_i),
    .pc_i   (pc_i),
    .code_i (code_i),
    .valid_o(s1_valid),
    .match_o(s1_match)
  );

  imm_gen u_imm_gen (
    .match_i(s1_match),
    .imm_o  (s1_imm)
  );

  operand_select u_operand_select (
    .match_i(s1_match),
    .rd_o   (s1_rd),
    .rs1_o  (s1_rs1),
    .rs2_o  (s1_rs2)
  );

  decode_assembler u_decode_assembler (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .valid_i(s1_valid),
    .match_i(s1_match),
    .imm_i  (s1_imm),
    .rd_i   (s1_rd),
    .rs1_i  (s1_rs1),
    .rs2_i  (s1_rs2),
    .valid_o(valid_o),
    .cmd_o  (cmd_o)
  );

endmodule

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f rv64_decoder.f \
  --top-module rv64_decoder_tb -o rv64_decoder_sim > sim.log 2>&1 \
  && ./obj_dir/rv64_decoder_sim >> sim.log 2>&1 \
  || echo "Build or run error, see sim.log"
if grep -q "Regression passed" sim.log; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1

// File: rv64_decoder.f
+incdir+verification
logic/rv64_decode_pkg.sv
logic/instr_matcher.sv
logic/imm_gen.sv
logic/operand_select.sv
logic/decode_assembler.sv
logic/rv64_decoder_top.sv
verification/rv64_decoder_tb.sv

// File: verification/decoder_ref.svh
`ifndef DECODER_REF_SVH
`define DECODER_REF_SVH

// Function index per funct3 or -1 where funct3 is not an instruction
localparam int BR_F3[8]   = '{BEQ, BNE, -1, -1, BLT, BGE, BLTU, BGEU};
localparam int LD_F3[8]   = '{LB, LH, LW, LD, LBU, LHU, LWU, -1};
localparam int ST_F3[8]   = '{SB, SH, SW, SD, -1, -1, -1, -1};
localparam int OPI_F3[8]  = '{ADDI, SLLI, SLTI, SLTIU, XORI, SRLI, ORI, ANDI};
localparam int OP_F3[8]   = '{ADD, SLL, SLT, SLTU, XOR, SRL, OR, AND};
localparam int OPIW_F3[8] = '{ADDIW, SLLIW, -1, -1, -1, SRLIW, -1, -1};
localparam int OPW_F3[8]  = '{ADDW, SLLW, -1, -1, -1, SRLW, -1, -1};
localparam int MULW_F3[8] = '{MULW, -1, -1, -1, DIVW, DIVUW, REMW, REMUW};

localparam logic [31:0] TSO_WORD   = 32'h8330000F;  // fm=1000, RW,RW
localparam logic [31:0] PAUSE_WORD = 32'h0100000F;  // pred=W, succ=0

function automatic xlen_t sign_ext(logic [31:0] v, int width);
  xlen_t r;
  r = xlen_t'(v);
  for (int i = width; i < XLEN; i++) r[i] = v[width-1];
  return r;
endfunction

// Table encoding of one function with free bits taken from fill
function automatic logic [31:0] place_fields(func_e f, logic [31:0] fill);
  return FUNC_MATCH[f] | (fill & ~FUNC_MASK[f]);
endfunction

// Field decode of opcode, funct3 and funct7
function automatic int ref_func_id(logic [31:0] c);
  logic [2:0] f3;
  logic [5:0] f6;
  logic [6:0] f7;
  f3 = c[14:12];
  f6 = c[31:26];
  f7 = c[31:25];
  case (c[6:0])
    7'h17: return AUIPC;
    7'h37: return LUI;
    7'h6F: return JAL;
    7'h67: return (f3 == 3'd0) ? int'(JALR) : -1;
    7'h63: return BR_F3[f3];
    7'h03: return LD_F3[f3];
    7'h23: return ST_F3[f3];
    7'h0F: return (f3 == 3'd0) ? int'(FENCE) : -1;
    7'h13: begin
      // RV64 shifts keep shamt[5] in bit 25
      if (f3 == 3'd5 && f6 == 6'h10) return SRAI;
      if ((f3 == 3'd1 || f3 == 3'd5) && f6 != 6'h00) return -1;
      return OPI_F3[f3];
    end
    7'h33: begin
      if (f7 == 7'h01) return int'(MUL) + f3;
      if (f7 == 7'h20) return (f3 == 3'd0) ? int'(SUB) : (f3 == 3'd5) ? int'(SRA) : -1;
      return (f7 == 7'h00) ? OP_F3[f3] : -1;
    end
    7'h1B: begin
      if (f3 == 3'd0) return ADDIW;
      if (f7 == 7'h20) return (f3 == 3'd5) ? int'(SRAIW) : -1;
      return (f7 == 7'h00) ? OPIW_F3[f3] : -1;
    end
    7'h3B: begin
      if (f7 == 7'h01) return MULW_F3[f3];
      if (f7 == 7'h20) return (f3 == 3'd0) ? int'(SUBW) : (f3 == 3'd5) ? int'(SRAW) : -1;
      return (f7 == 7'h00) ? OPW_F3[f3] : -1;
    end
    7'h73: return (c == 32'h00000073) ? int'(ECALL) : (c == 32'h00100073) ? int'(EBREAK) : -1;
    default: return -1;
  endcase
endfunction

function automatic decoded_instr_t ref_decode(logic [31:0] c, xlen_t pc);
  decoded_instr_t d;
  int id;
  d = '0;
  d.pc = pc;
  id = ref_func_id(c);
  if (id >= 0) d.func[id] = 1'b1;
  if (c == TSO_WORD) d.func[FENCE_TSO] = 1'b1;  // FENCE bit stays set too
  if (c == PAUSE_WORD) d.func[PAUSE] = 1'b1;
  if (|(d.func & XRD_FUNCS)) d.rd = c[11:7];
  if (|(d.func & XRS1_FUNCS)) d.rs1 = c[19:15];
  if (|(d.func & XRS2_FUNCS)) d.rs2 = c[24:20];
  if (|(d.func & AIMM_FUNCS)) d.imm = xlen_t'(c[25:20]);
  else if (|(d.func & BIMM_FUNCS))
    d.imm = sign_ext(32'({c[31], c[7], c[30:25], c[11:8], 1'b0}), 13);
  else if (|(d.func & IIMM_FUNCS)) d.imm = sign_ext(32'(c[31:20]), 12);
  else if (|(d.func & JIMM_FUNCS))
    d.imm = sign_ext(32'({c[31], c[19:12], c[20], c[30:21], 1'b0}), 21);
  else if (|(d.func & SIMM_FUNCS)) d.imm = sign_ext(32'({c[31:25], c[11:7]}), 12);
  else if (|(d.func & UIMM_FUNCS)) d.imm = xlen_t'({c[31:12], 12'h000});
  d.blocking = |(d.func & BLOCKING_FUNCS);
  // Bit 0 is always flagged
  d.reg_req = 32'h1 | (32'h1 << d.rd) | (32'h1 << d.rs1) | (32'h1 << d.rs2);
  if (d.blocking) d.reg_req = '1;
  return d;
endfunction

`endif

// File: verification/rv64_decoder_tb.sv
module rv64_decoder_tb;

  import rv64_decode_pkg::*;

  `include "decoder_ref.svh"

  localparam int N_RANDOM  = 300;
  localparam int N_EXTREME = 36;
  localparam int N_INSTR   = NUM_FUNCS + N_EXTREME + N_RANDOM;

  localparam logic [6:0] OPCODES[13] = '{7'h17, 7'h37, 7'h6F, 7'h67, 7'h63, 7'h03, 7'h23,
                                         7'h13, 7'h33, 7'h0F, 7'h73, 7'h1B, 7'h3B};
  localparam func_e IMM_FUNCS[9] = '{SLLIW, SRAI, BNE, ADDI, LD, JAL, SD, AUIPC, LUI};
  localparam logic [31:0] IMM_FILLS[4] = '{32'hFFFFFFFF, 32'h00000000, 32'h80000000,
                                           32'h7FFFFFFF};

  logic            clk_i;
  logic            rst_i;
  logic            valid_i;
  xlen_t           pc_i;
  logic [ILEN-1:0] code_i;
  logic            valid_o;
  decoded_instr_t  cmd_o;

  decoded_instr_t exp_q[$];
  int             due_q[$];
  int             cyc = 0;
  int             value_errs = 0;
  int             timing_errs = 0;
  int             proto_errs = 0;

  rv64_decoder_top UUT (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .valid_i(valid_i),
    .pc_i   (pc_i),
    .code_i (code_i),
    .valid_o(valid_o),
    .cmd_o  (cmd_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cyc <= cyc + 1;

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_func(string name, func_vec_t got, func_vec_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("[FAIL] %0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  task automatic check_idx(string name, reg_idx_t got, reg_idx_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("[FAIL] %0t %s got %0d exp %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_xlen(string name, xlen_t got, xlen_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("[FAIL] %0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  task automatic check_req(string name, reg_req_t got, reg_req_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("[FAIL] %0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      value_errs++;
      $display("[FAIL] %0t %s got %b exp %b", $time, name, got, exp);
    end
  endtask

  task automatic check_cmd(decoded_instr_t got, decoded_instr_t exp);
    check_func("cmd_o.func", got.func, exp.func);
    check_idx("cmd_o.rd", got.rd, exp.rd);
    check_idx("cmd_o.rs1", got.rs1, exp.rs1);
    check_idx("cmd_o.rs2", got.rs2, exp.rs2);
    check_xlen("cmd_o.imm", got.imm, exp.imm);
    check_xlen("cmd_o.pc", got.pc, exp.pc);
    check_flag("cmd_o.blocking", got.blocking, exp.blocking);
    check_req("cmd_o.reg_req", got.reg_req, exp.reg_req);
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // Strobe for one cycle and then an optional idle cycle
  task automatic send(logic [ILEN-1:0] code, bit gap);
    xlen_t pc;
    pc = {$urandom, $urandom};
    @(posedge clk_i);
    valid_i <= 1'b1;
    code_i  <= code;
    pc_i    <= pc;
    exp_q.push_back(ref_decode(code, pc));
    due_q.push_back(cyc + 3);  // cyc here is one edge behind
    if (gap) begin
      @(posedge clk_i);
      valid_i <= 1'b0;
      code_i  <= $urandom;  // Noise while idle
    end
  endtask

  function automatic logic [ILEN-1:0] rand_code();
    logic [ILEN-1:0] c;
    c = $urandom;
    if ($urandom_range(3) != 0) c[6:0] = OPCODES[$urandom_range(12)];
    return c;
  endfunction

  // Output monitor sampled mid-cycle
  always @(negedge clk_i) begin
    if (!rst_i && valid_o === 1'b1) begin
      if (exp_q.size() == 0) begin
        proto_errs++;
        $display("%0t valid_o high with no instruction outstanding", $time);
      end else begin
        if (cyc != due_q[0]) begin
          timing_errs++;
          $display("%0t valid_o came at edge %0d instead of %0d", $time, cyc, due_q[0]);
        end
        check_cmd(cmd_o, exp_q.pop_front());
        void'(due_q.pop_front());
      end
    end
  end

  initial begin
    logic [ILEN-1:0] code;
    func_vec_t       want;
    void'($urandom(32'h9328));
    rst_i   = 1'b1;
    valid_i = 1'b0;
    pc_i    = '0;
    code_i  = '0;
    repeat (10) @(posedge clk_i);
    rst_i <= 1'b0;
    repeat (4) begin  // Quiet outputs before any strobe
      @(negedge clk_i);
      check_flag("valid_o", valid_o, 1'b0);
      check_cmd(cmd_o, '0);
    end
    for (int f = 0; f < NUM_FUNCS; f++) begin
      code = place_fields(func_e'(f), $urandom);
      want = '0;
      want[f] = 1'b1;
      if (f == FENCE_TSO || f == PAUSE) want[FENCE] = 1'b1;
      if (ref_decode(code, '0).func !== want) begin
        value_errs++;
        $display("Reference decode of function %0d disagrees with its encoding", f);
      end
      send(code, 1'b0);
    end
    foreach (IMM_FUNCS[i]) begin
      foreach (IMM_FILLS[j]) send(place_fields(IMM_FUNCS[i], IMM_FILLS[j]), 1'b0);
    end
    repeat (N_RANDOM) send(rand_code(), $urandom_range(1) == 1);
    @(posedge clk_i);
    valid_i <= 1'b0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    if (exp_q.size() != 0) begin
      proto_errs++;
      $display("%0d instructions never produced valid_o", exp_q.size());
    end
    $display("Errors: value %0d, timing %0d, protocol %0d", value_errs, timing_errs, proto_errs);
    if (value_errs + timing_errs + proto_errs == 0) $display("Regression passed");
    else $display("Regression failed");
    $finish;
  end

  // Two cycles per instruction at most plus reset and drain
  initial begin
    #((N_INSTR + 50) * 10 * 2);
    $display("Timeout: the run did not finish in time");
    $display("Regression failed");
    $finish;
  end

endmodule
